// File: common/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    // Bit 7 marks a valid exception, bits 6..0 carry the code
    typedef logic [7:0]  ecode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  opcode_t;

    typedef struct packed {
        addr_t  pc;
        inst_t  inst;
        ecode_t ecode;
    } fetch_pkt_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    //////////////////////////////////////////////////
    // Fetch constants
    //////////////////////////////////////////////////
    localparam addr_t  RESET_PC        = 32'h1c00_0000;
    localparam int     ECODE_VALID_BIT = 7;
    localparam ecode_t ECODE_NONE      = 8'h00;
    // Misaligned fetch address
    localparam ecode_t ECODE_ADEF      = 8'h89;
    // Kernel half of the address space fetched from user level
    localparam ecode_t ECODE_ADEF_PRIV = 8'h88;
    localparam plv_t   PLV_USER        = 2'd3;

    localparam opcode_t OP_B  = 6'b010100;
    localparam opcode_t OP_BL = 6'b010101;

    // Fetch queue sizing
    localparam int FQ_DEPTH       = 4;
    localparam int FQ_PTR_W       = 2;
    localparam int FQ_STALL_LEVEL = 2;
    typedef logic [FQ_PTR_W-1:0] fq_ptr_t;
    typedef logic [FQ_PTR_W:0]   fq_cnt_t;

    // BTB: index from pc[4:2], tag from pc[31:5]
    localparam int BTB_ENTRIES = 8;
    localparam int BTB_IDX_W   = 3;
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    localparam int ROM_WORDS = 64;
    localparam int ROM_IDX_W = 6;
    typedef logic [ROM_IDX_W-1:0] rom_idx_t;

endpackage

// File: src/redirect_arbiter.sv
`timescale 1ns/10ps

module redirect_arbiter
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      era_en,
    input  addr_t     era_pc,
    input  logic      eentry_en,
    input  addr_t     eentry_pc,
    input  logic      csr_flush,
    input  addr_t     csr_flush_pc,
    input  logic      br_taken,
    input  addr_t     br_target,
    output redirect_t be_redirect
);

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_ERA,
        SRC_EENTRY,
        SRC_CSR,
        SRC_BR
    } redirect_src_e;

    redirect_src_e src;

    // Fixed priority, exception return first
    always_comb begin
        if (era_en) begin
            src = SRC_ERA;
        end else if (eentry_en) begin
            src = SRC_EENTRY;
        end else if (csr_flush) begin
            src = SRC_CSR;
        end else if (br_taken) begin
            src = SRC_BR;
        end else begin
            src = SRC_NONE;
        end
    end

    always_comb begin
        be_redirect.valid = (src != SRC_NONE);
        case (src)
            SRC_ERA:    be_redirect.target = era_pc;
            SRC_EENTRY: be_redirect.target = eentry_pc;
            SRC_CSR:    be_redirect.target = csr_flush_pc;
            SRC_BR:     be_redirect.target = br_target;
            default:    be_redirect.target = '0;
        endcase
    end

endmodule

// File: fetch_pc/fetch_pc.sv
`timescale 1ns/10ps

module fetch_pc
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  redirect_t be_redirect,
    input  redirect_t pd_redirect,
    input  addr_t     pc_predict,
    input  logic      fq_stall,
    input  plv_t      plv,
    output addr_t     pc_if1,
    output logic      if1_valid,
    output ecode_t    if1_ecode
);

    logic started_q;

    // Low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // PC register
    //////////////////////////////////////////////////
    // Back-end redirect, then predecoder, then stall, then BTB/sequential
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_if1 <= RESET_PC;
        end else if (be_redirect.valid) begin
            pc_if1 <= be_redirect.target;
        end else if (pd_redirect.valid) begin
            pc_if1 <= pd_redirect.target;
        end else if (!fq_stall && started_q) begin
            pc_if1 <= pc_predict;
        end
    end

    // Hold RESET_PC until it has been fetched once
    assign if1_valid = started_q & ~fq_stall
                     & ~be_redirect.valid & ~pd_redirect.valid;

    //////////////////////////////////////////////////
    // Fetch exception
    //////////////////////////////////////////////////
    always_comb begin
        if (pc_if1[1:0] != 2'b00) begin
            if1_ecode = ECODE_ADEF;
        end else if (pc_if1[31] && plv == PLV_USER) begin
            if1_ecode = ECODE_ADEF_PRIV;
        end else begin
            if1_ecode = ECODE_NONE;
        end
    end

endmodule

// File: fetch_pc/next_pc_predictor.sv
`timescale 1ns/10ps

module next_pc_predictor
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  addr_t pc_if1,
    input  logic  br_taken,
    input  addr_t br_pc,
    input  addr_t br_target,
    output addr_t pc_predict
);

    btb_tag_t               tag_q    [BTB_ENTRIES];
    addr_t                  target_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;
    btb_idx_t               rd_idx;
    btb_idx_t               wr_idx;
    logic                   hit;

    assign rd_idx = pc_if1[BTB_IDX_W+1:2];
    assign wr_idx = br_pc[BTB_IDX_W+1:2];

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////
    assign hit        = valid_q[rd_idx] && (tag_q[rd_idx] == pc_if1[31:BTB_IDX_W+2]);
    assign pc_predict = hit ? target_q[rd_idx] : pc_if1 + 32'd4;

    //////////////////////////////////////////////////
    // Update from taken back-end branches
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (br_taken) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Same-index entry is simply overwritten
    always_ff @(posedge clk) begin
        if (br_taken) begin
            tag_q[wr_idx]    <= br_pc[31:BTB_IDX_W+2];
            target_q[wr_idx] <= br_target;
        end
    end

endmodule

// File: fetch_pc/predecoder.sv
`timescale 1ns/10ps

module predecoder
    import fetch_pkg::*;
(
    input  fetch_pkt_t if2_pkt,
    input  logic       if2_valid,
    input  addr_t      pc_if1,
    output redirect_t  pd_redirect
);

    opcode_t     opcode;
    logic [25:0] offs26;
    addr_t       br_target;
    logic        is_direct_br;
    logic        pkt_ok;

    assign opcode = if2_pkt.inst[31:26];

    // B/BL split offset: offs[15:0] in inst[25:10], offs[25:16] in inst[9:0]
    assign offs26 = {if2_pkt.inst[9:0], if2_pkt.inst[25:10]};

    assign br_target = if2_pkt.pc + {{4{offs26[25]}}, offs26, 2'b00};

    assign is_direct_br = (opcode == OP_B) || (opcode == OP_BL);

    // Faulting packets carry a zero word, but gate on the ecode anyway
    assign pkt_ok = if2_valid && !if2_pkt.ecode[ECODE_VALID_BIT];

    //////////////////////////////////////////////////
    // Redirect only when IF1 went the wrong way
    //////////////////////////////////////////////////
    assign pd_redirect.valid  = pkt_ok && is_direct_br && (br_target != pc_if1);
    assign pd_redirect.target = br_target;

endmodule

// File: src/inst_rom.sv
`timescale 1ns/10ps

module inst_rom
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  addr_t      pc_if1,
    input  logic       if1_valid,
    input  ecode_t     if1_ecode,
    input  redirect_t  be_redirect,
    output fetch_pkt_t if2_pkt,
    output logic       if2_valid
);

    inst_t    rom [ROM_WORDS];
    rom_idx_t rom_idx;

    initial begin
        $readmemh("bench/fetch_prog.hex", rom);
    end

    // Word index relative to the reset vector, wraps every 256 bytes
    assign rom_idx = rom_idx_t'((pc_if1 - RESET_PC) >> 2);

    always_ff @(posedge clk) begin
        if (if1_valid) begin
            if2_pkt.pc    <= pc_if1;
            if2_pkt.inst  <= if1_ecode[ECODE_VALID_BIT] ? '0 : rom[rom_idx];
            if2_pkt.ecode <= if1_ecode;
        end
    end

    // Back-end redirect kills whatever IF1 holds
    always_ff @(posedge clk) begin
        if (!rstn) begin
            if2_valid <= 1'b0;
        end else if (be_redirect.valid) begin
            if2_valid <= 1'b0;
        end else begin
            if2_valid <= if1_valid;
        end
    end

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  fetch_pkt_t if2_pkt,
    input  logic       if2_valid,
    input  redirect_t  be_redirect,
    output logic       fq_stall,
    output fetch_pkt_t inst_pkt,
    output logic       inst_req,
    input  logic       inst_ack
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_WAIT_ACK_LOW
    } hs_state_e;

    fetch_pkt_t buf_q [FQ_DEPTH];
    fq_ptr_t    wr_ptr;
    fq_ptr_t    rd_ptr;
    fq_ptr_t    rd_ptr_next;
    fq_cnt_t    count;
    fq_cnt_t    count_next;
    hs_state_e  state;
    logic       flush;
    logic       wr_en;
    logic       pop;
    logic       keep_head;
    logic       can_req;

    assign flush     = be_redirect.valid;
    assign wr_en     = if2_valid & ~flush;
    assign pop       = (state == HS_REQ) & inst_ack;
    // Head already offered but not yet acked survives a flush
    assign keep_head = (state == HS_REQ) & ~inst_ack;
    assign can_req   = (count != '0) & ~flush;

    assign rd_ptr_next = rd_ptr + fq_ptr_t'(pop);

    always_comb begin
        if (flush) begin
            count_next = keep_head ? fq_cnt_t'(1) : '0;
        end else begin
            count_next = count + fq_cnt_t'(wr_en) - fq_cnt_t'(pop);
        end
    end

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            buf_q[wr_ptr] <= if2_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr_next;
            count  <= count_next;
            if (flush) begin
                wr_ptr <= rd_ptr_next + fq_ptr_t'(keep_head);
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Four-phase output handshake
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE:         if (can_req) state <= HS_REQ;
                HS_REQ:          if (inst_ack) state <= HS_WAIT_ACK_LOW;
                HS_WAIT_ACK_LOW: if (!inst_ack) state <= can_req ? HS_REQ : HS_IDLE;
                default:         state <= HS_IDLE;
            endcase
        end
    end

    assign inst_req = (state == HS_REQ);
    assign inst_pkt = buf_q[rd_ptr];

    // Leaves room for the two packets still in IF1/IF2
    assign fq_stall = (count >= fq_cnt_t'(FQ_STALL_LEVEL));

endmodule

// File: src/fetch_top.sv
`timescale 1ns/10ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       era_en,
    input  addr_t      era_pc,
    input  logic       eentry_en,
    input  addr_t      eentry_pc,
    input  logic       csr_flush,
    input  addr_t      csr_flush_pc,
    input  logic       br_taken,
    input  addr_t      br_pc,
    input  addr_t      br_target,
    input  plv_t       plv,
    output fetch_pkt_t inst_pkt,
    output logic       inst_req,
    input  logic       inst_ack
);

    redirect_t  be_redirect;
    redirect_t  pd_redirect;
    addr_t      pc_predict;
    addr_t      pc_if1;
    logic       if1_valid;
    ecode_t     if1_ecode;
    fetch_pkt_t if2_pkt;
    logic       if2_valid;
    logic       fq_stall;

    redirect_arbiter u_redirect_arbiter (
        .clk(clk), .rstn(rstn),
        .era_en(era_en), .era_pc(era_pc),
        .eentry_en(eentry_en), .eentry_pc(eentry_pc),
        .csr_flush(csr_flush), .csr_flush_pc(csr_flush_pc),
        .br_taken(br_taken), .br_target(br_target),
        .be_redirect(be_redirect)
    );

    fetch_pc u_fetch_pc (
        .clk(clk), .rstn(rstn),
        .be_redirect(be_redirect), .pd_redirect(pd_redirect),
        .pc_predict(pc_predict), .fq_stall(fq_stall), .plv(plv),
        .pc_if1(pc_if1), .if1_valid(if1_valid), .if1_ecode(if1_ecode)
    );

    next_pc_predictor u_next_pc_predictor (
        .clk(clk), .rstn(rstn), .pc_if1(pc_if1),
        .br_taken(br_taken), .br_pc(br_pc), .br_target(br_target),
        .pc_predict(pc_predict)
    );

    inst_rom u_inst_rom (
        .clk(clk), .rstn(rstn),
        .pc_if1(pc_if1), .if1_valid(if1_valid), .if1_ecode(if1_ecode),
        .be_redirect(be_redirect),
        .if2_pkt(if2_pkt), .if2_valid(if2_valid)
    );

    predecoder u_predecoder (
        .if2_pkt(if2_pkt), .if2_valid(if2_valid), .pc_if1(pc_if1),
        .pd_redirect(pd_redirect)
    );

    fetch_queue u_fetch_queue (
        .clk(clk), .rstn(rstn),
        .if2_pkt(if2_pkt), .if2_valid(if2_valid), .be_redirect(be_redirect),
        .fq_stall(fq_stall),
        .inst_pkt(inst_pkt), .inst_req(inst_req), .inst_ack(inst_ack)
    );

endmodule

// File: bench/fetch_asserts.sv
`timescale 1ns/10ps

module fetch_asserts
    import fetch_pkg::*;
(
    input logic       clk,
    input logic       rstn,
    input logic       inst_req,
    input logic       inst_ack,
    input fetch_pkt_t inst_pkt,
    input logic       wr_en,
    input fq_cnt_t    count
);

    int fail_count = 0;

    //////////////////////////////////////////////////
    // Four-phase output handshake
    //////////////////////////////////////////////////
    req_held: assert property (@(posedge clk) disable iff (!rstn)
        inst_req && !inst_ack |=> inst_req)
        else begin
            fail_count++;
            $error("inst_req dropped before inst_ack");
        end

    pkt_stable: assert property (@(posedge clk) disable iff (!rstn)
        inst_req && !inst_ack |=> $stable(inst_pkt))
        else begin
            fail_count++;
            $error("inst_pkt changed while inst_req was high");
        end

    req_drops_on_ack: assert property (@(posedge clk) disable iff (!rstn)
        inst_req && inst_ack |=> !inst_req)
        else begin
            fail_count++;
            $error("inst_req still high after inst_ack");
        end

    // No new request until ack is seen low
    req_low_while_ack: assert property (@(posedge clk) disable iff (!rstn)
        !inst_req && inst_ack |=> !inst_req)
        else begin
            fail_count++;
            $error("inst_req rose while inst_ack was high");
        end

    //////////////////////////////////////////////////
    // Queue occupancy
    //////////////////////////////////////////////////
    no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
        count == fq_cnt_t'(FQ_DEPTH) |-> !wr_en)
        else begin
            fail_count++;
            $error("fetch queue written while full");
        end

endmodule

bind fetch_queue fetch_asserts u_fetch_asserts (
    .clk(clk),
    .rstn(rstn),
    .inst_req(inst_req),
    .inst_ack(inst_ack),
    .inst_pkt(inst_pkt),
    .wr_en(wr_en),
    .count(count)
);

// File: bench/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb
    import fetch_pkg::*;
();

    // Forward B at word 2 of the program and its target
    localparam addr_t B_PC       = RESET_PC + 32'h08;
    localparam addr_t B_TARGET   = RESET_PC + 32'h14;
    localparam int    WAIT_LIMIT = 100;

    logic       clk;
    logic       rstn;
    logic       era_en;
    addr_t      era_pc;
    logic       eentry_en;
    addr_t      eentry_pc;
    logic       csr_flush;
    addr_t      csr_flush_pc;
    logic       br_taken;
    addr_t      br_pc;
    addr_t      br_target;
    plv_t       plv;
    fetch_pkt_t inst_pkt;
    logic       inst_req;
    logic       inst_ack;

    inst_t       prog [ROM_WORDS];
    logic [31:0] rng;
    addr_t       exp_pc;
    plv_t        exp_plv;
    logic        redirect_pending;
    addr_t       pending_pc;
    plv_t        pending_plv;
    int          check_errors;
    int          timeouts;

    fetch_top u_fetch_top (
        .clk(clk), .rstn(rstn),
        .era_en(era_en), .era_pc(era_pc),
        .eentry_en(eentry_en), .eentry_pc(eentry_pc),
        .csr_flush(csr_flush), .csr_flush_pc(csr_flush_pc),
        .br_taken(br_taken), .br_pc(br_pc), .br_target(br_target),
        .plv(plv),
        .inst_pkt(inst_pkt), .inst_req(inst_req), .inst_ack(inst_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic ecode_t expected_ecode(input addr_t pc, input plv_t lvl);
        if (pc[1:0] != 2'b00) begin
            return ECODE_ADEF;
        end else if (pc[31] && lvl == 2'd3) begin
            return ECODE_ADEF_PRIV;
        end
        return 8'h00;
    endfunction

    function automatic inst_t expected_inst(input addr_t pc);
        logic [31:0] word;
        word = (pc - RESET_PC) >> 2;
        return prog[word % ROM_WORDS];
    endfunction

    // Branch target for B/BL, otherwise the next word
    function automatic addr_t branch_successor(input addr_t pc, input inst_t inst);
        logic [25:0] offs;
        offs = {inst[9:0], inst[25:10]};
        if (inst[31:26] != OP_B && inst[31:26] != OP_BL) begin
            return pc + 32'd4;
        end
        return pc + {{4{offs[25]}}, offs, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("error %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_packet();
        ecode_t e_ecode;
        inst_t  e_inst;
        e_ecode = expected_ecode(exp_pc, exp_plv);
        if (e_ecode[ECODE_VALID_BIT]) begin
            e_inst = '0;
        end else begin
            e_inst = expected_inst(exp_pc);
        end
        check_value("inst_pkt.pc", exp_pc, inst_pkt.pc);
        check_value("inst_pkt.inst", e_inst, inst_pkt.inst);
        check_value("inst_pkt.ecode", e_ecode, inst_pkt.ecode);
        if (redirect_pending) begin
            exp_pc           = pending_pc;
            exp_plv          = pending_plv;
            redirect_pending = 1'b0;
        end else begin
            exp_pc = branch_successor(exp_pc, e_inst);
        end
    endtask

    //////////////////////////////////////////////////
    // Consumer and redirect stimulus
    //////////////////////////////////////////////////
    task automatic wait_req_high(output bit seen);
        int cycles;
        cycles = 0;
        while (!inst_req && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        seen = inst_req;
        if (!seen) begin
            timeouts++;
            $display("timeout at %0t, inst_req never rose", $time);
        end
    endtask

    task automatic take_packets(input int num);
        int delay;
        int hold;
        int cycles;
        bit seen;
        for (int n = 0; n < num; n++) begin
            wait_req_high(seen);
            if (seen) begin
                rng   = next_random(rng);
                delay = int'(rng % 32'd6);
                repeat (delay) @(negedge clk);
                check_packet();
                inst_ack = 1'b1;
                cycles   = 0;
                do begin
                    @(negedge clk);
                    cycles++;
                end while (inst_req && cycles < WAIT_LIMIT);
                if (inst_req) begin
                    timeouts++;
                    $display("timeout at %0t, inst_req stayed high after inst_ack", $time);
                end
                // Ack lingers past the drop of inst_req
                rng  = next_random(rng);
                hold = 1 + int'(rng % 32'd2);
                repeat (hold) @(negedge clk);
                inst_ack = 1'b0;
            end
        end
    endtask

    // srcs is {era, eentry, csr flush, branch}; the offered head survives
    task automatic apply_redirect(input logic [3:0] srcs, input addr_t target,
                                  input plv_t new_plv);
        bit seen;
        wait_req_high(seen);
        // Unselected sources carry their own decoy targets
        era_en           = srcs[3];
        era_pc           = srcs[3] ? target : ~target;
        eentry_en        = srcs[2];
        eentry_pc        = srcs[2] ? target : target + 32'h40;
        csr_flush        = srcs[1];
        csr_flush_pc     = srcs[1] ? target : target + 32'h80;
        br_taken         = srcs[0];
        br_pc            = B_PC;
        br_target        = B_TARGET;
        plv              = new_plv;
        redirect_pending = 1'b1;
        pending_pc       = (srcs[3:1] != 3'b000) ? target : B_TARGET;
        pending_plv      = new_plv;
        @(negedge clk);
        era_en    = 1'b0;
        eentry_en = 1'b0;
        csr_flush = 1'b0;
        br_taken  = 1'b0;
    endtask

    initial begin
        int assert_fails;
        rstn         = 1'b0;
        inst_ack     = 1'b0;
        plv          = 2'd0;
        era_en       = 1'b0;
        era_pc       = '0;
        eentry_en    = 1'b0;
        eentry_pc    = '0;
        csr_flush    = 1'b0;
        csr_flush_pc = '0;
        br_taken     = 1'b0;
        br_pc        = '0;
        br_target    = '0;
        rng              = 32'hc3039bcb;
        check_errors     = 0;
        timeouts         = 0;
        redirect_pending = 1'b0;
        exp_pc           = RESET_PC;
        exp_plv          = 2'd0;
        $readmemh("bench/fetch_prog.hex", prog);
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        check_value("inst_req", 32'd0, inst_req);

        // Sequential stream with forward B, BL and the backward loop
        take_packets(30);
        // Era beats a simultaneous branch, BTB learns the B
        apply_redirect(4'b1001, RESET_PC + 32'h04, 2'd0);
        take_packets(12);
        apply_redirect(4'b0001, 32'h0, 2'd0);
        take_packets(20);
        apply_redirect(4'b0001, 32'h0, 2'd0);
        take_packets(20);
        apply_redirect(4'b0100, RESET_PC + 32'h30, 2'd0);
        take_packets(6);
        apply_redirect(4'b0010, RESET_PC + 32'h24, 2'd0);
        take_packets(6);

        // Fetch exceptions
        apply_redirect(4'b0100, RESET_PC + 32'h22, 2'd0);
        take_packets(5);
        apply_redirect(4'b0010, 32'h8000_0010, 2'd3);
        take_packets(5);
        apply_redirect(4'b0100, 32'h8000_0010, 2'd0);
        take_packets(15);

        // Long run under random ack delays
        apply_redirect(4'b1000, RESET_PC, 2'd0);
        take_packets(60);

        assert_fails = u_fetch_top.u_fetch_queue.u_fetch_asserts.fail_count;
        $display("check errors %0d, assertion failures %0d, timeouts %0d",
                 check_errors, assert_fails, timeouts);
        if (check_errors + assert_fails + timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: bench/fetch_prog.hex
// One 32-bit instruction word per line in hex
// Word 0 sits at the reset pc, later words follow at pc + 4
02800c0c
0280100d
50000c00
0280140e
0280180f
00150010
54000800
00150011
00150012
02bffc13
03400000
0280041a
53ffd3ff
03400000

// File: fetch_frontend.f
common/fetch_pkg.sv
src/redirect_arbiter.sv
fetch_pc/fetch_pc.sv
fetch_pc/next_pc_predictor.sv
fetch_pc/predecoder.sv
src/inst_rom.sv
src/fetch_queue.sv
src/fetch_top.sv
bench/fetch_asserts.sv
bench/fetch_tb.sv
